// ==== axisCalc.sv ====
/* Axis arithmetic
   Collects set/reset samples from read bytes, derives offsets and axes */
`timescale 1ns/1ps
`default_nettype none

module axisCalc (
  input  logic               clk,
  input  logic               rst,
  input  magPkg::rxByte_t    rx,
  input  logic               capture,
  input  magPkg::sampleSel_e sel,
  input  magPkg::calcOp_e    calc,
  output magPkg::axes_t      axes,
  output magPkg::axes_t      offsets
);

  magPkg::axes_t setBank;
  magPkg::axes_t resetBank;
  logic [5:0]    bytePos;

  function automatic magPkg::axis_t halfSum(input magPkg::axis_t a, input magPkg::axis_t b);
    logic [magPkg::axisWidth:0] sum;
    sum = {1'b0, a} + {1'b0, b};
    return sum[magPkg::axisWidth:1];
  endfunction

  function automatic magPkg::axis_t halfDiff(input magPkg::axis_t a, input magPkg::axis_t b);
    logic [magPkg::axisWidth:0] diff;
    diff = {1'b0, a} - {1'b0, b};
    return diff[magPkg::axisWidth:1];
  endfunction

  // Byte 0 lands in the top of x
  assign bytePos = 6'(40 - 8 * rx.idx);

  always_ff @(posedge clk) begin
    if (capture && rx.valid) begin
      if (sel == magPkg::selSet)
        setBank[bytePos +: 8] <= rx.data;
      else
        resetBank[bytePos +: 8] <= rx.data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      axes <= '0;
      offsets <= '0;
    end else begin
      case (calc)
        magPkg::calcCalibrate: begin
          offsets.x <= halfSum(setBank.x, resetBank.x);
          offsets.y <= halfSum(setBank.y, resetBank.y);
          offsets.z <= halfSum(setBank.z, resetBank.z);
          axes.x <= halfDiff(setBank.x, resetBank.x);
          axes.y <= halfDiff(setBank.y, resetBank.y);
          axes.z <= halfDiff(setBank.z, resetBank.z);
        end
        magPkg::calcMeasure: begin
          axes.x <= setBank.x - offsets.x;   // Wraps mod 2^16
          axes.y <= setBank.y - offsets.y;
          axes.z <= setBank.z - offsets.z;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== i2cByteEngine.sv ====
/* I2C master engine, one complete register transaction per command
   Open-drain SCL/SDA enables, bit timing from a quarter-bit counter */
`timescale 1ns/1ps
`default_nettype none

module i2cByteEngine #(
  parameter int quarterClks = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  magPkg::i2cCmd_t cmd,
  input  logic            cmdStart,
  input  logic            sdaIn,
  output logic            cmdDone,
  output magPkg::rxByte_t rx,
  output logic            sclOe,
  output logic            sdaOe
);

  localparam int cntW = $clog2(quarterClks);

  typedef enum logic [2:0] {
    busIdle,
    busStart,
    busAddr,
    busWrite,
    busWriteAck,
    busRead,
    busReadAck,
    busStop
  } busState_e;

  busState_e       state;
  logic [cntW-1:0] qCnt;
  logic [1:0]      qPhase;      // Quarter within the current bit
  logic            tick;
  logic            sampleTick;
  logic            endTick;
  logic            lowQuarter;
  logic            lastRead;
  magPkg::i2cCmd_t cmdReg;
  logic [7:0]      txShift;
  logic [7:0]      rxShift;
  logic            ackBit;
  logic [2:0]      bitCnt;
  logic [2:0]      byteCnt;

  assign tick = (qCnt == cntW'(quarterClks - 1));
  assign sampleTick = tick && (qPhase == 2'd1);   // SCL rising quarter
  assign endTick = tick && (qPhase == 2'd3);
  assign lowQuarter = (qPhase == 2'd0) || (qPhase == 2'd3);
  assign lastRead = (byteCnt == cmdReg.rdLen - 3'd1);

  // Quarter-bit timebase, parked while idle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      qCnt <= '0;
      qPhase <= 2'd0;
    end else if (state == busIdle) begin
      qCnt <= '0;
      qPhase <= 2'd0;
    end else if (tick) begin
      qCnt <= '0;
      qPhase <= qPhase + 2'd1;
    end else begin
      qCnt <= qCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state == busIdle && cmdStart) begin
      cmdReg <= cmd;
      txShift <= {magPkg::deviceAddr, cmd.op == magPkg::opRead};
    end else if (endTick && (state == busAddr || state == busWrite)) begin
      txShift <= {txShift[6:0], 1'b0};   // MSB first
    end else if (endTick && state == busWriteAck) begin
      txShift <= (byteCnt == 3'd0) ? cmdReg.regAddr : cmdReg.wrData;
    end
    if (sampleTick && state == busRead)
      rxShift <= {rxShift[6:0], sdaIn};
    if (sampleTick && state == busWriteAck)
      ackBit <= sdaIn;   // High means NACK
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= busIdle;
      bitCnt <= 3'd0;
      byteCnt <= 3'd0;
      cmdDone <= 1'b0;
      rx <= '0;
    end else begin
      cmdDone <= 1'b0;
      rx.valid <= 1'b0;
      case (state)
        busIdle: begin
          bitCnt <= 3'd0;
          byteCnt <= 3'd0;
          if (cmdStart)
            state <= busStart;
        end
        busStart:
          if (endTick)
            state <= busAddr;
        busAddr, busWrite, busRead:
          if (endTick) begin
            bitCnt <= bitCnt + 3'd1;   // Wraps to zero after bit 7
            if (bitCnt == 3'd7 && state == busRead) begin
              state <= busReadAck;
              rx.valid <= 1'b1;
              rx.idx <= byteCnt;
              rx.data <= rxShift;
            end else if (bitCnt == 3'd7) begin
              state <= busWriteAck;
            end
          end
        busWriteAck:
          if (endTick) begin
            if (ackBit) begin
              state <= busStop;
            end else if (byteCnt == 3'd0 && cmdReg.op == magPkg::opRead) begin
              state <= busRead;
            end else if (byteCnt == 3'd0 ||
                         (byteCnt == 3'd1 && cmdReg.op == magPkg::opRegWrite)) begin
              state <= busWrite;
              byteCnt <= byteCnt + 3'd1;
            end else begin
              state <= busStop;
            end
          end
        busReadAck:
          if (endTick) begin
            if (lastRead) begin
              state <= busStop;
            end else begin
              state <= busRead;
              byteCnt <= byteCnt + 3'd1;
            end
          end
        busStop:
          if (endTick) begin
            state <= busIdle;
            cmdDone <= 1'b1;
          end
        default: state <= busIdle;
      endcase
    end
  end

  // Line drivers, high enable pulls the line low
  always_comb begin
    sclOe = 1'b0;
    sdaOe = 1'b0;
    case (state)
      busStart: begin
        sclOe = (qPhase == 2'd3);
        sdaOe = qPhase[1];    // SDA falls while SCL high
      end
      busAddr, busWrite: begin
        sclOe = lowQuarter;
        sdaOe = ~txShift[7];
      end
      busWriteAck, busRead: sclOe = lowQuarter;
      busReadAck: begin
        sclOe = lowQuarter;
        sdaOe = ~lastRead;    // NACK on the final byte
      end
      busStop: begin
        sclOe = (qPhase == 2'd0);
        sdaOe = ~qPhase[1];   // SDA rises while SCL high
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== list.f ====
magPkg.sv
i2cByteEngine.sv
sensorSequencer.sv
axisCalc.sv
magCompass.sv
sensorModel.sv
magCompassTb.sv

// ==== magCompass.sv ====
/* Compass controller top level
   Sequencer, I2C engine and axis arithmetic */
`timescale 1ns/1ps
`default_nettype none

module magCompass #(
  parameter int quarterClks = 4   // Clk cycles per quarter SCL period
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          calibrate,
  input  logic          measure,
  input  logic          sdaIn,
  output logic          sclOe,
  output logic          sdaOe,
  output logic          busy,
  output logic          resultValid,
  output magPkg::axes_t axes,
  output magPkg::axes_t offsets
);

  magPkg::i2cCmd_t    cmd;
  logic               cmdStart;
  logic               cmdDone;
  magPkg::rxByte_t    rx;
  magPkg::sampleSel_e sel;
  logic               capture;
  magPkg::calcOp_e    calc;

  sensorSequencer u_seq (
    .clk(clk), .rst(rst), .calibrate(calibrate), .measure(measure),
    .cmdDone(cmdDone), .rx(rx), .cmd(cmd), .cmdStart(cmdStart),
    .sel(sel), .capture(capture), .calc(calc),
    .busy(busy), .resultValid(resultValid)
  );

  i2cByteEngine #(.quarterClks(quarterClks)) u_engine (
    .clk(clk), .rst(rst), .cmd(cmd), .cmdStart(cmdStart), .sdaIn(sdaIn),
    .cmdDone(cmdDone), .rx(rx), .sclOe(sclOe), .sdaOe(sdaOe)
  );

  axisCalc u_calc (
    .clk(clk), .rst(rst), .rx(rx), .capture(capture), .sel(sel),
    .calc(calc), .axes(axes), .offsets(offsets)
  );

endmodule

`default_nettype wire

// ==== magCompassTb.sv ====
/* Compass controller testbench
   Calibrate and measure runs against the sensor model, checked by assertions */
`timescale 1ns/1ps
`default_nettype none

module magCompassTb;

  localparam int quarterClks = 4;
  // Five sequences of up to ~25 transactions at ~1500 cycles each, plus margin
  localparam int timeoutCycles = 300000;
  localparam logic [47:0] calOrder = {magPkg::ctrlRefill, magPkg::ctrlReset,
                                      magPkg::ctrlMeasure, magPkg::ctrlRefill,
                                      magPkg::ctrlSet, magPkg::ctrlMeasure};

  logic          clk;
  logic          rst;
  logic          calibrate;
  logic          measure;
  logic          sclOe;
  logic          sdaOe;
  logic          sdaIn;
  logic          busy;
  logic          resultValid;
  magPkg::axes_t axes;
  magPkg::axes_t offsets;
  magPkg::axes_t base;
  magPkg::axes_t field;
  magPkg::axes_t expAxes;
  magPkg::axes_t expOffsets;
  logic [47:0]   ctrlHist;
  logic          modelErr;
  logic          calRun;
  logic [31:0]   lcgState;
  int            cycleCount = 0;

  magCompass #(.quarterClks(quarterClks)) DUT (
    .clk(clk), .rst(rst), .calibrate(calibrate), .measure(measure),
    .sdaIn(sdaIn), .sclOe(sclOe), .sdaOe(sdaOe), .busy(busy),
    .resultValid(resultValid), .axes(axes), .offsets(offsets)
  );

  sensorModel model (
    .clk(clk), .rst(rst), .sclOe(sclOe), .sdaOe(sdaOe), .base(base),
    .field(field), .sdaIn(sdaIn), .ctrlHist(ctrlHist), .err(modelErr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic failRun(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
      failRun("timeout: the DUT did not finish its sequences in time");
  end

  // Reset values, checked once the clock has run a few cycles
  resetState: assert property (@(posedge clk) rst && cycleCount > 2 |->
      !busy && !resultValid && !sclOe && !sdaOe && axes == '0 && offsets == '0)
    else failRun($sformatf("mismatch at %0t: outputs not at reset values", $time));

  noOverlap: assert property (@(posedge clk) disable iff (rst) !(busy && resultValid))
    else failRun($sformatf("mismatch at %0t: busy and resultValid both high", $time));

  // resultValid only drops when a new request is taken
  validHolds: assert property (@(posedge clk) disable iff (rst)
      $fell(resultValid) |-> $rose(busy))
    else failRun($sformatf("mismatch at %0t: resultValid fell without a request", $time));

  doneEdge: assert property (@(posedge clk) disable iff (rst)
      $rose(resultValid) |-> $fell(busy))
    else failRun($sformatf("mismatch at %0t: resultValid rose while busy held", $time));

  offsetCheck: assert property (@(posedge clk) disable iff (rst)
      $rose(resultValid) |-> offsets == expOffsets)
    else failRun($sformatf("mismatch at %0t: offsets %h, expected %h",
                           $time, $sampled(offsets), expOffsets));

  axesCheck: assert property (@(posedge clk) disable iff (rst)
      $rose(resultValid) |-> axes == expAxes)
    else failRun($sformatf("mismatch at %0t: axes %h, expected %h",
                           $time, $sampled(axes), expAxes));

  ctrlOrder: assert property (@(posedge clk) disable iff (rst)
      $rose(resultValid) && calRun |-> ctrlHist == calOrder)
    else failRun($sformatf("mismatch at %0t: control writes %h, expected %h",
                           $time, $sampled(ctrlHist), calOrder));

  modelClean: assert property (@(posedge clk) disable iff (rst) !modelErr)
    else failRun("the sensor model saw a bus protocol or sequencing error");

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic drawAxis(output magPkg::axis_t b, output magPkg::axis_t f);
    lcgState = lcgNext(lcgState);
    b = 16'h4000 + {2'b00, lcgState[29:16]};   // 0x4000 to 0x7fff
    lcgState = lcgNext(lcgState);
    f = {4'h0, lcgState[27:16]};   // Small enough that base +- field never wraps
  endtask

  task automatic newField;
    drawAxis(base.x, field.x);
    drawAxis(base.y, field.y);
    drawAxis(base.z, field.z);
  endtask

  task automatic nextCycle;
    @(posedge clk);
    #1;
  endtask

  // One request, held until busy, then wait for the result
  task automatic runSequence(input logic doCal, input logic alsoMeasure);
    calRun = doCal;
    if (doCal) begin
      expOffsets = base;   // Half the sum of set and reset
      expAxes = field;     // Half their difference
    end else begin
      expAxes.x = base.x + field.x - expOffsets.x;
      expAxes.y = base.y + field.y - expOffsets.y;
      expAxes.z = base.z + field.z - expOffsets.z;
    end
    nextCycle();
    calibrate = doCal;
    measure = !doCal || alsoMeasure;
    nextCycle();
    while (!busy)
      nextCycle();
    calibrate = 1'b0;
    measure = 1'b0;
    while (!resultValid)
      nextCycle();
    repeat (5)
      nextCycle();
  endtask

  initial begin
    rst = 1'b1;
    calibrate = 1'b0;
    measure = 1'b0;
    calRun = 1'b0;
    lcgState = 32'h6c40a137;
    base = '0;
    field = '0;
    expAxes = '0;
    expOffsets = '0;
    repeat (10)
      @(posedge clk);
    #1;
    rst = 1'b0;
    newField();
    runSequence(1'b1, 1'b0);
    newField();
    runSequence(1'b0, 1'b0);
    runSequence(1'b0, 1'b0);   // Same field, same result
    newField();
    runSequence(1'b1, 1'b1);   // Both requests high, calibrate wins
    newField();
    runSequence(1'b0, 1'b0);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== magPkg.sv ====
/* Compass controller shared definitions
   Sensor register map, command values, transfer structs and FSM enums */
`default_nettype none

package magPkg;

  // 7-bit target address of the compass sensor
  localparam logic [6:0] deviceAddr = 7'h30;

  // Register map
  localparam logic [7:0] dataReg = 8'h00;     // First of six data bytes
  localparam logic [7:0] statusReg = 8'h06;
  localparam logic [7:0] control0Reg = 8'h07;

  // Control register 0 commands
  localparam logic [7:0] ctrlRefill = 8'h80;
  localparam logic [7:0] ctrlReset = 8'h40;
  localparam logic [7:0] ctrlSet = 8'h20;
  localparam logic [7:0] ctrlMeasure = 8'h01;

  // Status byte flags
  localparam int statusMeasDoneBit = 0;
  localparam int statusPumpBusyBit = 1;

  localparam int axisWidth = 16;

  typedef logic [axisWidth-1:0] axis_t;

  typedef struct packed {
    axis_t x;
    axis_t y;
    axis_t z;
  } axes_t;

  typedef enum logic [1:0] {
    opRegWrite,   // Address, register, one data byte
    opPtrWrite,   // Address, register only
    opRead        // Address, then rdLen bytes
  } txnOp_e;

  typedef struct packed {
    txnOp_e     op;
    logic [7:0] regAddr;
    logic [7:0] wrData;
    logic [2:0] rdLen;   // 1 to 6
  } i2cCmd_t;

  typedef struct packed {
    logic       valid;
    logic [2:0] idx;     // Byte position within the read
    logic [7:0] data;
  } rxByte_t;

  typedef enum logic {
    selSet,
    selReset
  } sampleSel_e;

  typedef enum logic [1:0] {
    calcNone,
    calcCalibrate,
    calcMeasure
  } calcOp_e;

  typedef enum logic [3:0] {
    seqIdle,
    seqRefill,
    seqPumpPtr,
    seqPumpRead,
    seqPulse,
    seqMeasWrite,
    seqMeasPtr,
    seqMeasRead,
    seqDataPtr,
    seqDataRead,
    seqCalc
  } seqState_e;

endpackage

`default_nettype wire

// ==== sensorModel.sv ====
/* Compass sensor model, I2C target for the testbench
   Status polling, SET/RESET state, six data bytes and bus protocol checks */
`timescale 1ns/1ps
`default_nettype none

module sensorModel (
  input  logic          clk,
  input  logic          rst,
  input  logic          sclOe,
  input  logic          sdaOe,
  input  magPkg::axes_t base,
  input  magPkg::axes_t field,
  output logic          sdaIn,
  output logic [47:0]   ctrlHist,   // Last six control-0 writes, newest in the low byte
  output logic          err
);

  logic          scl;
  logic          sda;
  logic          prevScl;
  logic          prevSda;
  logic          active;      // Between START and STOP
  logic          rose;        // SCL high phase seen since the last fall
  logic          lastBit;
  logic          rwBit;
  logic          readPhase;   // Target is sending data bytes
  logic          ackDrive;
  logic          magSet;      // Magnetisation from the last pulse
  logic          pumpReady;
  logic [3:0]    bitIdx;
  logic [2:0]    byteNum;
  logic [7:0]    shiftIn;
  logic [7:0]    txByte;
  logic [7:0]    regPtr;
  int            pumpLeft;
  int            measLeft;
  int            statusReads;
  int            notReady;
  magPkg::axes_t sample;

  // Pull-ups on both lines, wired-AND with the DUT enables
  assign scl = !sclOe;
  assign sda = !(sdaOe || ackDrive || (readPhase && bitIdx < 4'd8 && !txByte[7]));
  assign sdaIn = sda;

  task automatic flag(input string what);
    $display("sensor model error at %0t: %s", $time, what);
    err = 1'b1;
  endtask

  task automatic writeControl(input logic [7:0] val);
    ctrlHist = {ctrlHist[39:0], val};
    case (val)
      magPkg::ctrlRefill: begin
        pumpLeft = 2;
        pumpReady = 1'b0;
      end
      magPkg::ctrlReset, magPkg::ctrlSet: begin
        if (!pumpReady)
          flag("SET or RESET pulse sent while the charge pump was still busy");
        magSet = (val == magPkg::ctrlSet);
        pumpReady = 1'b0;   // Pulse drains the capacitor
      end
      magPkg::ctrlMeasure: begin
        measLeft = 3;
        statusReads = 0;
        notReady = 0;
        sample.x = magSet ? base.x + field.x : base.x - field.x;
        sample.y = magSet ? base.y + field.y : base.y - field.y;
        sample.z = magSet ? base.z + field.z : base.z - field.z;
      end
      default: flag("unknown value written to control register 0");
    endcase
  endtask

  // Next byte the target sends
  task automatic loadTxByte;
    if (regPtr == magPkg::statusReg) begin
      txByte = 8'h00;
      txByte[magPkg::statusPumpBusyBit] = (pumpLeft > 0);
      txByte[magPkg::statusMeasDoneBit] = (measLeft == 0);
      if (pumpLeft > 0)
        pumpLeft = pumpLeft - 1;
      else
        pumpReady = 1'b1;
      if (measLeft > 0) begin
        measLeft = measLeft - 1;
        notReady = notReady + 1;
      end
      statusReads = statusReads + 1;
    end else if (regPtr < 8'd6) begin
      if (regPtr == magPkg::dataReg && statusReads < notReady + 1)
        flag("data read before the measurement was reported done");
      txByte = sample[47 - 8 * int'(regPtr) -: 8];   // High byte first
      regPtr = regPtr + 8'd1;
    end else begin
      txByte = 8'h00;
    end
  endtask

  task automatic takeByte;
    case (byteNum)
      3'd0: begin
        if (shiftIn[7:1] != magPkg::deviceAddr)
          flag("transaction addressed a device other than the compass");
        rwBit = shiftIn[0];
      end
      3'd1: regPtr = shiftIn;
      3'd2:
        if (regPtr == magPkg::control0Reg)
          writeControl(shiftIn);
        else
          flag("data written to a register other than control 0");
      default: flag("too many bytes written in one transaction");
    endcase
    byteNum = byteNum + 3'd1;
  endtask

  // Bit completes on the SCL falling edge
  task automatic commitBit;
    if (bitIdx < 4'd8) begin
      shiftIn = {shiftIn[6:0], lastBit};
      if (readPhase)
        txByte = {txByte[6:0], 1'b1};
      bitIdx = bitIdx + 4'd1;
      if (bitIdx == 4'd8 && !readPhase) begin
        ackDrive = 1'b1;   // Target acks every byte
        takeByte();
      end
    end else begin
      bitIdx = 4'd0;
      ackDrive = 1'b0;
      if (readPhase) begin
        if (lastBit)
          readPhase = 1'b0;   // NACK from the master
        else
          loadTxByte();
      end else if (byteNum == 3'd1 && rwBit) begin
        readPhase = 1'b1;
        loadTxByte();
      end
    end
  endtask

  always @(negedge clk or posedge rst) begin
    if (rst) begin
      prevScl = 1'b1;
      prevSda = 1'b1;
      active = 1'b0;
      rose = 1'b0;
      lastBit = 1'b1;
      rwBit = 1'b0;
      readPhase = 1'b0;
      ackDrive = 1'b0;
      magSet = 1'b1;
      pumpReady = 1'b0;
      bitIdx = 4'd0;
      byteNum = 3'd0;
      shiftIn = 8'h00;
      txByte = 8'hff;
      regPtr = 8'h00;
      pumpLeft = 0;
      measLeft = 0;
      statusReads = 0;
      notReady = 0;
      sample = '0;
      ctrlHist = '0;
      err = 1'b0;
    end else begin
      if (prevScl && scl && prevSda != sda) begin
        if (!sda) begin   // START
          if (active)
            flag("START seen inside a transaction");
          active = 1'b1;
          rose = 1'b0;
          bitIdx = 4'd0;
          byteNum = 3'd0;
          readPhase = 1'b0;
        end else begin    // STOP
          if (!active || bitIdx != 4'd0)
            flag("STOP seen away from a byte boundary");
          active = 1'b0;
          readPhase = 1'b0;
          ackDrive = 1'b0;
        end
      end else if (!prevScl && scl) begin
        if (prevSda != sda)
          flag("SDA changed together with the SCL rising edge");
        rose = 1'b1;
        lastBit = sda;
      end else if (prevScl && !scl && active && rose) begin
        rose = 1'b0;
        commitBit();
      end
      prevScl = scl;
      prevSda = sda;
    end
  end

endmodule

`default_nettype wire

// ==== sensorSequencer.sv ====
/* Compass sequencer FSM
   Walks the measure and calibrate transaction sequences and flags results */
`timescale 1ns/1ps
`default_nettype none

module sensorSequencer (
  input  logic               clk,
  input  logic               rst,
  input  logic               calibrate,
  input  logic               measure,
  input  logic               cmdDone,
  input  magPkg::rxByte_t    rx,
  output magPkg::i2cCmd_t    cmd,
  output logic               cmdStart,
  output magPkg::sampleSel_e sel,
  output logic               capture,
  output magPkg::calcOp_e    calc,
  output logic               busy,
  output logic               resultValid
);

  magPkg::seqState_e state;
  magPkg::seqState_e nextState;
  logic              calMode;    // Calibration sequence running
  logic              setPhase;   // Second calibration phase
  logic [7:0]        status;

  assign busy = (state != magPkg::seqIdle);
  assign capture = (state == magPkg::seqDataRead);
  assign sel = (calMode && !setPhase) ? magPkg::selReset : magPkg::selSet;

  always_comb begin
    calc = magPkg::calcNone;
    if (state == magPkg::seqCalc)
      calc = calMode ? magPkg::calcCalibrate : magPkg::calcMeasure;
  end

  // Last status byte seen during a poll
  always_ff @(posedge clk) begin
    if (rx.valid && (state == magPkg::seqPumpRead || state == magPkg::seqMeasRead))
      status <= rx.data;
  end

  // Step taken when the current transaction finishes
  always_comb begin
    nextState = state;
    case (state)
      magPkg::seqRefill:    nextState = magPkg::seqPumpPtr;
      magPkg::seqPumpPtr:   nextState = magPkg::seqPumpRead;
      magPkg::seqPumpRead:
        nextState = status[magPkg::statusPumpBusyBit] ? magPkg::seqPumpPtr : magPkg::seqPulse;
      magPkg::seqPulse:     nextState = magPkg::seqMeasWrite;
      magPkg::seqMeasWrite: nextState = magPkg::seqMeasPtr;
      magPkg::seqMeasPtr:   nextState = magPkg::seqMeasRead;
      magPkg::seqMeasRead:
        nextState = status[magPkg::statusMeasDoneBit] ? magPkg::seqDataPtr : magPkg::seqMeasPtr;
      magPkg::seqDataPtr:   nextState = magPkg::seqDataRead;
      magPkg::seqDataRead:
        nextState = (calMode && !setPhase) ? magPkg::seqRefill : magPkg::seqCalc;
      default:              nextState = state;
    endcase
  end

  // Transaction for the current step
  always_comb begin
    cmd.op = magPkg::opRegWrite;
    cmd.regAddr = magPkg::control0Reg;
    cmd.wrData = magPkg::ctrlMeasure;
    cmd.rdLen = 3'd1;
    case (state)
      magPkg::seqRefill: cmd.wrData = magPkg::ctrlRefill;
      magPkg::seqPulse:  cmd.wrData = setPhase ? magPkg::ctrlSet : magPkg::ctrlReset;
      magPkg::seqPumpPtr, magPkg::seqMeasPtr: begin
        cmd.op = magPkg::opPtrWrite;
        cmd.regAddr = magPkg::statusReg;
      end
      magPkg::seqDataPtr: begin
        cmd.op = magPkg::opPtrWrite;
        cmd.regAddr = magPkg::dataReg;
      end
      magPkg::seqPumpRead, magPkg::seqMeasRead: cmd.op = magPkg::opRead;
      magPkg::seqDataRead: begin
        cmd.op = magPkg::opRead;
        cmd.rdLen = 3'd6;   // X, y, z high byte first
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= magPkg::seqIdle;
      calMode <= 1'b0;
      setPhase <= 1'b0;
      cmdStart <= 1'b0;
      resultValid <= 1'b0;
    end else begin
      cmdStart <= 1'b0;
      case (state)
        magPkg::seqIdle:
          if (calibrate || measure) begin
            calMode <= calibrate;   // Calibrate wins
            setPhase <= 1'b0;
            resultValid <= 1'b0;
            cmdStart <= 1'b1;
            state <= calibrate ? magPkg::seqRefill : magPkg::seqMeasWrite;
          end
        magPkg::seqCalc: begin
          resultValid <= 1'b1;
          state <= magPkg::seqIdle;
        end
        default:
          if (cmdDone) begin
            state <= nextState;
            cmdStart <= (nextState != magPkg::seqCalc);
            if (state == magPkg::seqDataRead && calMode)
              setPhase <= 1'b1;   // RESET phase done, SET next
          end
      endcase
    end
  end

endmodule

`default_nettype wire
